// File: agc_pkg.sv
package agc_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Widths and types
    ///////////////////////////////////////////////////////////////////////
    typedef logic        [7:0]  wb_adr_t;
    typedef logic        [31:0] wb_dat_t;
    typedef logic        [16:0] agc_scale_t;  // Unsigned gain scale
    typedef logic signed [15:0] agc_offset_t;
    typedef logic        [2:0]  info_idx_t;

    localparam int BOOT_COUNT = 31;
    typedef logic [$clog2(BOOT_COUNT+1)-1:0] boot_cnt_t;

    typedef enum logic [3:0] {
        BOOT_DELAY, RESETTING, POLLING, WAITING, READING,
        CALCULATING, WRITING, LOADING, APPLYING
    } loop_state_t;

    typedef enum logic [1:0] {COMM_SENDING, COMM_WAITING, COMM_PROCESSING} comm_state_t;
    typedef enum logic [1:0] {PORT_IDLE, PORT_READ, PORT_WRITE, PORT_ACK} port_state_t;

    ///////////////////////////////////////////////////////////////////////
    // Start values and loop constants
    ///////////////////////////////////////////////////////////////////////
    localparam agc_scale_t  START_SCALE    = 17'd1800;
    localparam agc_offset_t START_OFFSET   = 16'sd0;
    localparam agc_scale_t  SCALE_DELTA    = 17'd30;
    localparam agc_offset_t OFFSET_DELTA   = 16'sd25;
    localparam int          TARGET_RMS_SQ  = 16;
    localparam int          RMS_SQ_ERR     = 0;
    localparam int          OFFSET_ERR     = 5;
    localparam int          TIMESCALE_BITS = 4;
    localparam agc_scale_t  SCALE_MIN_CUT  = 17'h0012C;
    localparam agc_scale_t  SCALE_MAX_CUT  = 17'h1FBD0;
    localparam int          INFO_WORDS     = 6;

    // Statistics word positions
    localparam int IDX_RMS_SQ    = 1;
    localparam int IDX_CNT_ABOVE = 2;
    localparam int IDX_CNT_BELOW = 3;
    localparam int IDX_SCALE     = 4;
    localparam int IDX_OFFSET    = 5;

    // AGC module register map
    localparam wb_adr_t ADR_CTRL   = 8'h00;
    localparam wb_adr_t ADR_SCALE  = 8'h10;
    localparam wb_adr_t ADR_OFFSET = 8'h14;
    localparam wb_dat_t CMD_RESET  = 32'h04;
    localparam wb_dat_t CMD_START  = 32'h01;
    localparam wb_dat_t CMD_LOAD   = 32'h300;
    localparam wb_dat_t CMD_APPLY  = 32'h400;
    localparam int      STATUS_DONE_BIT = 1;

endpackage

// File: agc_seq_counter.sv
`timescale 1ns/10ps

module agc_seq_counter import agc_pkg::*; (
    input  logic      aclk,
    input  logic      wb_rst_i,
    input  logic      loop_rst_i,
    input  logic      boot_load_i,
    input  logic      info_clear_i,
    input  logic      info_step_i,
    output logic      boot_done_o,
    output info_idx_t info_idx_o,
    output logic      info_last_o
);

    boot_cnt_t boot_cnt_q;

    always_ff @(posedge aclk) begin
        if (wb_rst_i || loop_rst_i) begin
            boot_cnt_q <= boot_cnt_t'(BOOT_COUNT);
            info_idx_o <= '0;
        end else begin
            if (boot_load_i)
                boot_cnt_q <= boot_cnt_t'(BOOT_COUNT);
            else if (boot_cnt_q != '0)
                boot_cnt_q <= boot_cnt_q - 1'b1;  // Stops at zero

            // Word index, also picks scale or offset while writing
            if (info_clear_i)
                info_idx_o <= '0;
            else if (info_step_i)
                info_idx_o <= info_idx_o + 1'b1;
        end
    end

    assign boot_done_o = (boot_cnt_q == '0);
    assign info_last_o = (info_idx_o == info_idx_t'(INFO_WORDS));

endmodule

// File: agc_info_regs.sv
`timescale 1ns/10ps

module agc_info_regs import agc_pkg::*; (
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  logic        loop_rst_i,
    input  logic        capture_i,
    input  info_idx_t   capture_idx_i,
    input  wb_dat_t     capture_dat_i,
    input  logic        apply_i,
    input  agc_scale_t  new_scale_i,
    input  agc_offset_t new_offset_i,
    input  info_idx_t   rd_idx_i,
    output wb_dat_t     rd_dat_o,
    output wb_dat_t     rms_sq_o,
    output wb_dat_t     cnt_above_o,
    output wb_dat_t     cnt_below_o,
    output agc_scale_t  cur_scale_o,
    output agc_offset_t cur_offset_o
);

    wb_dat_t info_q [INFO_WORDS];  // Copy of the AGC module statistics

    always_ff @(posedge aclk) begin
        if (wb_rst_i || loop_rst_i) begin
            for (int i = 0; i < INFO_WORDS; i++) begin
                info_q[i] <= '0;
            end
        end else if (apply_i) begin
            // Applied values replace the read-back ones
            info_q[IDX_SCALE]  <= wb_dat_t'(new_scale_i);
            info_q[IDX_OFFSET] <= wb_dat_t'($unsigned(new_offset_i));  // Zero extended
        end else if (capture_i) begin
            info_q[capture_idx_i] <= capture_dat_i;
        end
    end

    // Host read, words past the last one read as zero
    assign rd_dat_o = (rd_idx_i < info_idx_t'(INFO_WORDS)) ? info_q[rd_idx_i] : '0;

    assign rms_sq_o     = info_q[IDX_RMS_SQ];
    assign cnt_above_o  = info_q[IDX_CNT_ABOVE];
    assign cnt_below_o  = info_q[IDX_CNT_BELOW];
    assign cur_scale_o  = agc_scale_t'(info_q[IDX_SCALE]);
    assign cur_offset_o = agc_offset_t'(info_q[IDX_OFFSET]);

endmodule

// File: agc_step_calc.sv
`timescale 1ns/10ps

module agc_step_calc import agc_pkg::*; (
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  logic        loop_rst_i,
    input  logic        calc_en_i,
    input  wb_dat_t     rms_sq_i,
    input  wb_dat_t     cnt_above_i,
    input  wb_dat_t     cnt_below_i,
    input  agc_scale_t  cur_scale_i,
    input  agc_offset_t cur_offset_i,
    output agc_scale_t  next_scale_o,
    output agc_offset_t next_offset_o
);

    logic [7+TIMESCALE_BITS:0] rms_adj;  // RMS squared on the reduced timescale
    logic                      rms_high;
    logic                      rms_low;
    logic                      above_heavy;
    logic                      below_heavy;

    assign rms_adj  = rms_sq_i[24:17-TIMESCALE_BITS];
    assign rms_high = rms_adj > (TARGET_RMS_SQ + RMS_SQ_ERR);
    assign rms_low  = rms_adj < (TARGET_RMS_SQ - RMS_SQ_ERR);

    // One extra bit so the error margin cannot wrap
    assign above_heavy = {1'b0, cnt_above_i} > ({1'b0, cnt_below_i} + 33'(OFFSET_ERR));
    assign below_heavy = {1'b0, cnt_below_i} > ({1'b0, cnt_above_i} + 33'(OFFSET_ERR));

    always_ff @(posedge aclk) begin
        if (wb_rst_i || loop_rst_i) begin
            next_scale_o  <= START_SCALE;
            next_offset_o <= START_OFFSET;
        end else if (calc_en_i) begin
            // Scale steps against the RMS error, held inside the cutoffs
            if (rms_high) begin
                if (cur_scale_i > SCALE_MIN_CUT)
                    next_scale_o <= cur_scale_i - SCALE_DELTA;
                else
                    next_scale_o <= cur_scale_i;
            end else if (rms_low) begin
                if (cur_scale_i < SCALE_MAX_CUT)
                    next_scale_o <= cur_scale_i + SCALE_DELTA;
                else
                    next_scale_o <= cur_scale_i;
            end

            // Offset balances the over and under counts
            if (above_heavy)
                next_offset_o <= cur_offset_i - OFFSET_DELTA;
            else if (below_heavy)
                next_offset_o <= cur_offset_i + OFFSET_DELTA;
        end
    end

endmodule

// File: agc_status_port.sv
`timescale 1ns/10ps

module agc_status_port import agc_pkg::*; (
    input  logic      aclk,
    input  logic      wb_rst_i,
    input  logic      cyc_i,
    input  logic      stb_i,
    input  logic      we_i,
    input  wb_adr_t   adr_i,
    output logic      ack_o,
    output wb_dat_t   dat_o,
    output info_idx_t rd_idx_o,
    input  wb_dat_t   rd_dat_i
);

    port_state_t state_q;
    wb_dat_t     resp_q;

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state_q <= PORT_IDLE;
        end else begin
            case (state_q)
                PORT_IDLE: begin
                    if (cyc_i && stb_i) state_q <= we_i ? PORT_WRITE : PORT_READ;
                end
                PORT_READ:  state_q <= PORT_ACK;
                PORT_WRITE: state_q <= PORT_ACK;  // Acknowledged, nothing stored
                default:    state_q <= PORT_IDLE;
            endcase
        end
    end

    // Bit 6 selects the step sizes, otherwise a statistics word
    always_ff @(posedge aclk) begin
        if (state_q == PORT_READ) begin
            if (adr_i[6]) begin
                case (adr_i[5:2])
                    4'd0:    resp_q <= wb_dat_t'(SCALE_DELTA);
                    4'd1:    resp_q <= wb_dat_t'(OFFSET_DELTA);  // Sign extends
                    default: resp_q <= '0;
                endcase
            end else begin
                resp_q <= adr_i[5] ? '0 : rd_dat_i;
            end
        end
    end

    assign rd_idx_o = adr_i[4:2];
    assign ack_o    = (state_q == PORT_ACK);
    assign dat_o    = resp_q;

endmodule

// File: agc_loop_fsm.sv
`timescale 1ns/10ps

module agc_loop_fsm import agc_pkg::*; (
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  logic        loop_rst_i,
    input  logic        wb_ack_i,
    input  wb_dat_t     wb_dat_i,
    input  logic        boot_done_i,
    input  logic        info_last_i,
    input  info_idx_t   info_idx_i,
    input  agc_scale_t  next_scale_i,
    input  agc_offset_t next_offset_i,
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    output wb_adr_t     wb_adr_o,
    output wb_dat_t     wb_dat_o,
    output logic        boot_load_o,
    output logic        info_clear_o,
    output logic        info_step_o,
    output logic        capture_o,
    output wb_dat_t     capture_dat_o,
    output logic        calc_en_o,
    output logic        apply_o
);

    loop_state_t state_q, state_d;
    comm_state_t comm_q;
    wb_dat_t     resp_q;      // Last read word from the AGC module
    logic        xfer_done;
    logic        proc;
    logic        status_done;
    logic        bus_req;
    logic        req_we;
    wb_adr_t     req_adr;
    wb_dat_t     req_dat;

    assign xfer_done   = (comm_q == COMM_WAITING) && wb_ack_i;
    assign proc        = (comm_q == COMM_PROCESSING);
    assign status_done = resp_q[STATUS_DONE_BIT];

    // No transfer in boot, calc, or once all six words are in
    assign bus_req = (state_q != BOOT_DELAY) && (state_q != CALCULATING) &&
                     !((state_q == READING) && info_last_i);

    // Request for the current loop state
    always_comb begin
        req_we  = 1'b1;
        req_adr = ADR_CTRL;
        req_dat = '0;
        case (state_q)
            WRITING: begin
                if (info_idx_i == '0) begin
                    req_adr = ADR_SCALE;
                    req_dat = wb_dat_t'(next_scale_i);
                end else begin
                    req_adr = ADR_OFFSET;
                    req_dat = wb_dat_t'(next_offset_i);  // Sign extends
                end
            end
            LOADING:   req_dat = CMD_LOAD;
            APPLYING:  req_dat = CMD_APPLY;
            RESETTING: req_dat = CMD_RESET;
            POLLING:   req_dat = CMD_START;
            WAITING:   req_we  = 1'b0;        // Status poll
            READING: begin
                req_we  = 1'b0;
                req_adr = wb_adr_t'({info_idx_i, 2'b00});
            end
            default:   req_we  = 1'b0;
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // Loop sequencing
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            BOOT_DELAY:  if (boot_done_i) state_d = WRITING;
            WRITING:     if (xfer_done && info_idx_i != '0) state_d = LOADING;
            LOADING:     if (xfer_done) state_d = APPLYING;
            APPLYING:    if (xfer_done) state_d = RESETTING;
            RESETTING:   if (xfer_done) state_d = POLLING;
            POLLING:     if (xfer_done) state_d = WAITING;
            WAITING:     if (proc && status_done) state_d = READING;
            READING:     if (info_last_i) state_d = CALCULATING;
            CALCULATING: state_d = WRITING;
            default:     state_d = BOOT_DELAY;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i || loop_rst_i) begin
            state_q  <= BOOT_DELAY;
            comm_q   <= COMM_SENDING;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            case (comm_q)
                COMM_SENDING: begin
                    if (bus_req) begin
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        wb_we_o  <= req_we;
                        comm_q   <= COMM_WAITING;
                    end
                end
                COMM_WAITING: begin
                    if (wb_ack_i) begin
                        wb_cyc_o <= 1'b0;
                        wb_stb_o <= 1'b0;
                        wb_we_o  <= 1'b0;
                        comm_q   <= wb_we_o ? COMM_SENDING : COMM_PROCESSING;
                    end
                end
                default: comm_q <= COMM_SENDING;
            endcase
        end
    end

    // Address, write data and read data
    always_ff @(posedge aclk) begin
        if (comm_q == COMM_SENDING && bus_req) begin
            wb_adr_o <= req_adr;
            wb_dat_o <= req_dat;
        end
        if (xfer_done) resp_q <= wb_dat_i;
    end

    assign boot_load_o   = (state_q == BOOT_DELAY) && boot_done_i;  // Re-arm the delay
    assign capture_o     = (state_q == READING) && proc;
    assign capture_dat_o = resp_q;
    assign info_step_o   = capture_o ||
                           ((state_q == WRITING) && xfer_done && info_idx_i == '0);
    assign info_clear_o  = ((state_q == READING) && info_last_i) ||
                           ((state_q == WRITING) && xfer_done && info_idx_i != '0);
    assign calc_en_o     = (state_q == CALCULATING);
    assign apply_o       = (state_q == APPLYING) && xfer_done;

endmodule

// File: agc_control_loop.sv
`timescale 1ns/10ps

module agc_control_loop import agc_pkg::*; (
    input  logic    aclk,
    input  logic    wb_rst_i,
    input  logic    agc_reset_i,

    // Master port to the AGC module
    output logic    wb_agc_module_cyc_o,
    output logic    wb_agc_module_stb_o,
    output logic    wb_agc_module_we_o,
    output wb_adr_t wb_agc_module_adr_o,
    output wb_dat_t wb_agc_module_dat_o,
    output logic [3:0] wb_agc_module_sel_o,
    input  wb_dat_t wb_agc_module_dat_i,
    input  logic    wb_agc_module_ack_i,

    // Host target port
    input  logic    wb_agc_controller_cyc_i,
    input  logic    wb_agc_controller_stb_i,
    input  logic    wb_agc_controller_we_i,
    input  wb_adr_t wb_agc_controller_adr_i,
    input  wb_dat_t wb_agc_controller_dat_i,
    input  logic [3:0] wb_agc_controller_sel_i,
    output logic    wb_agc_controller_ack_o,
    output wb_dat_t wb_agc_controller_dat_o
);

    logic        boot_load, info_clear, info_step;
    logic        boot_done, info_last;
    info_idx_t   info_idx;
    logic        capture, calc_en, apply;
    wb_dat_t     capture_dat;
    agc_scale_t  next_scale, cur_scale;
    agc_offset_t next_offset, cur_offset;
    wb_dat_t     rms_sq, cnt_above, cnt_below;
    info_idx_t   rd_idx;
    wb_dat_t     rd_dat;

    ///////////////////////////////////////////////////////////////////////
    // Control loop
    ///////////////////////////////////////////////////////////////////////
    agc_loop_fsm i_fsm (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .loop_rst_i(agc_reset_i),
        .wb_ack_i(wb_agc_module_ack_i), .wb_dat_i(wb_agc_module_dat_i),
        .boot_done_i(boot_done), .info_last_i(info_last), .info_idx_i(info_idx),
        .next_scale_i(next_scale), .next_offset_i(next_offset),
        .wb_cyc_o(wb_agc_module_cyc_o), .wb_stb_o(wb_agc_module_stb_o),
        .wb_we_o(wb_agc_module_we_o), .wb_adr_o(wb_agc_module_adr_o),
        .wb_dat_o(wb_agc_module_dat_o),
        .boot_load_o(boot_load), .info_clear_o(info_clear), .info_step_o(info_step),
        .capture_o(capture), .capture_dat_o(capture_dat),
        .calc_en_o(calc_en), .apply_o(apply)
    );

    agc_seq_counter i_cnt (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .loop_rst_i(agc_reset_i),
        .boot_load_i(boot_load), .info_clear_i(info_clear), .info_step_i(info_step),
        .boot_done_o(boot_done), .info_idx_o(info_idx), .info_last_o(info_last)
    );

    agc_info_regs i_info (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .loop_rst_i(agc_reset_i),
        .capture_i(capture), .capture_idx_i(info_idx), .capture_dat_i(capture_dat),
        .apply_i(apply), .new_scale_i(next_scale), .new_offset_i(next_offset),
        .rd_idx_i(rd_idx), .rd_dat_o(rd_dat),
        .rms_sq_o(rms_sq), .cnt_above_o(cnt_above), .cnt_below_o(cnt_below),
        .cur_scale_o(cur_scale), .cur_offset_o(cur_offset)
    );

    agc_step_calc i_calc (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .loop_rst_i(agc_reset_i),
        .calc_en_i(calc_en), .rms_sq_i(rms_sq),
        .cnt_above_i(cnt_above), .cnt_below_i(cnt_below),
        .cur_scale_i(cur_scale), .cur_offset_i(cur_offset),
        .next_scale_o(next_scale), .next_offset_o(next_offset)
    );

    // Host side read-back
    agc_status_port i_port (
        .aclk(aclk), .wb_rst_i(wb_rst_i),
        .cyc_i(wb_agc_controller_cyc_i), .stb_i(wb_agc_controller_stb_i),
        .we_i(wb_agc_controller_we_i), .adr_i(wb_agc_controller_adr_i),
        .ack_o(wb_agc_controller_ack_o), .dat_o(wb_agc_controller_dat_o),
        .rd_idx_o(rd_idx), .rd_dat_i(rd_dat)
    );

    assign wb_agc_module_sel_o = {4{wb_agc_module_cyc_o}};  // Full words only

endmodule

// File: agc_control_loop_checker.sv
`timescale 1ns/10ps

module agc_control_loop_checker import agc_pkg::*; (
    input logic    aclk,
    input logic    wb_rst_i,
    input logic    agc_reset_i,
    input logic    wb_agc_module_cyc_o,
    input logic    wb_agc_module_stb_o,
    input logic    wb_agc_module_we_o,
    input wb_adr_t wb_agc_module_adr_o,
    input wb_dat_t wb_agc_module_dat_o,
    input logic    wb_agc_module_ack_i,
    input logic    wb_agc_controller_ack_o
);

    stb_in_cyc: assert property (@(posedge aclk) disable iff (wb_rst_i)
        wb_agc_module_stb_o |-> wb_agc_module_cyc_o)
        else $error("AGC bus strobe outside a bus cycle");

    // Request held until the ack arrives
    req_stable: assert property (@(posedge aclk) disable iff (wb_rst_i || agc_reset_i)
        wb_agc_module_stb_o && !wb_agc_module_ack_i |=>
            $stable(wb_agc_module_adr_o) && $stable(wb_agc_module_we_o) &&
            $stable(wb_agc_module_dat_o))
        else $error("AGC bus request changed before its ack");

    ack_single: assert property (@(posedge aclk) disable iff (wb_rst_i)
        wb_agc_controller_ack_o |=> !wb_agc_controller_ack_o)
        else $error("Host ack high for two cycles");

    cyc_in_reset: assert property (@(posedge aclk)
        wb_rst_i && $past(wb_rst_i) |-> !wb_agc_module_cyc_o)
        else $error("AGC bus cycle open during reset");

endmodule

bind agc_control_loop agc_control_loop_checker i_checker (.*);

// File: agc_control_loop_tb.sv
`timescale 1ns/10ps

module agc_control_loop_tb import agc_pkg::*; ();

    localparam int ROUNDS    = 6;
    localparam int STIM_COLS = 9;    // Six words, poll count, scale, offset
    localparam int REQ_LIMIT = 200;  // Cycles, covers the boot delay
    localparam int ACK_LIMIT = 20;

    logic       aclk = 1'b0;
    logic       wb_rst_i;
    logic       agc_reset_i;
    logic       m_cyc, m_stb, m_we, m_ack;
    logic [3:0] m_sel, h_sel;
    wb_adr_t    m_adr, h_adr;
    wb_dat_t    m_dat_o, m_dat_i;
    logic       h_cyc, h_stb, h_we, h_ack;
    wb_dat_t    h_dat_i, h_dat_o;

    wb_dat_t    stim_mem [ROUNDS*STIM_COLS];
    integer     seed;
    int         errors;
    int         timeouts;
    int         wait_cycles;
    logic       req_we;
    wb_adr_t    req_adr;
    wb_dat_t    req_dat;

    always #20 aclk = ~aclk;

    agc_control_loop i_dut (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_reset_i(agc_reset_i),
        .wb_agc_module_cyc_o(m_cyc), .wb_agc_module_stb_o(m_stb),
        .wb_agc_module_we_o(m_we), .wb_agc_module_adr_o(m_adr),
        .wb_agc_module_dat_o(m_dat_o), .wb_agc_module_sel_o(m_sel),
        .wb_agc_module_dat_i(m_dat_i), .wb_agc_module_ack_i(m_ack),
        .wb_agc_controller_cyc_i(h_cyc), .wb_agc_controller_stb_i(h_stb),
        .wb_agc_controller_we_i(h_we), .wb_agc_controller_adr_i(h_adr),
        .wb_agc_controller_dat_i(h_dat_i), .wb_agc_controller_sel_i(h_sel),
        .wb_agc_controller_ack_o(h_ack), .wb_agc_controller_dat_o(h_dat_o)
    );

    task automatic check_value(input wb_dat_t actual, input wb_dat_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("Checks done with %0d mismatches and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    ///////////////////////////////////////////////////////////////////////
    // AGC module model
    ///////////////////////////////////////////////////////////////////////
    task automatic wait_request(input string what);
        wait_cycles = 0;
        if (timeouts == 0) begin
            do begin
                @(posedge aclk);
                #2;
                wait_cycles++;
            end while (!(m_cyc && m_stb) && wait_cycles < REQ_LIMIT);
            if (!(m_cyc && m_stb)) begin
                $display("Timeout at %0t ns: the loop never started the %s transfer",
                         $time, what);
                timeouts++;
            end else begin
                check_value(wb_dat_t'(m_sel), 32'h0000000f, {what, " byte select"});
            end
        end
        req_we  = m_we;
        req_adr = m_adr;
        req_dat = m_dat_o;
    endtask

    // Ack one to three cycles after the request was seen
    task automatic send_ack(input wb_dat_t rdata);
        int gap;
        if (timeouts == 0) begin
            gap = 1 + int'($unsigned($random(seed)) % 3);
            repeat (gap - 1) begin
                @(posedge aclk);
                #2;
            end
            m_ack   = 1'b1;
            m_dat_i = rdata;
            @(posedge aclk);
            #2;
            m_ack   = 1'b0;
            m_dat_i = '0;
        end
    endtask

    task automatic expect_write(input wb_adr_t adr, input wb_dat_t dat, input string what);
        wait_request(what);
        if (timeouts == 0) begin
            check_value(wb_dat_t'(req_we), 32'd1, {what, " write enable"});
            check_value(wb_dat_t'(req_adr), wb_dat_t'(adr), {what, " address"});
            check_value(req_dat, dat, {what, " data"});
            send_ack('0);
        end
    endtask

    task automatic expect_read(input wb_adr_t adr, input string what);
        wait_request(what);
        if (timeouts == 0) begin
            check_value(wb_dat_t'(req_we), 32'd0, {what, " write enable"});
            check_value(wb_dat_t'(req_adr), wb_dat_t'(adr), {what, " address"});
        end
    endtask

    task automatic expect_commands();
        expect_write(ADR_CTRL, CMD_LOAD, "load command");
        expect_write(ADR_CTRL, CMD_APPLY, "apply command");
        expect_write(ADR_CTRL, CMD_RESET, "counter reset command");
        expect_write(ADR_CTRL, CMD_START, "start command");
    endtask

    task automatic expect_startup();
        expect_write(ADR_SCALE, wb_dat_t'(START_SCALE), "start scale");
        if (timeouts == 0) begin
            // BOOT_COUNT+1 cycles of delay, then one cycle to issue the request
            check_value(wb_dat_t'(wait_cycles), wb_dat_t'(BOOT_COUNT + 2),
                        "boot delay length");
        end
        expect_write(ADR_OFFSET, wb_dat_t'(START_OFFSET), "start offset");
        expect_commands();
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Host side reads
    ///////////////////////////////////////////////////////////////////////
    task automatic host_read(input wb_adr_t adr, input wb_dat_t expected, input string what);
        int cycles;
        cycles = 0;
        if (timeouts == 0) begin
            h_cyc = 1'b1;
            h_stb = 1'b1;
            h_we  = 1'b0;
            h_adr = adr;
            do begin
                @(posedge aclk);
                #2;
                cycles++;
            end while (!h_ack && cycles < ACK_LIMIT);
            if (!h_ack) begin
                $display("Timeout at %0t ns: the status port never acknowledged %s",
                         $time, what);
                timeouts++;
            end else begin
                check_value(wb_dat_t'(cycles), 32'd2, {what, " ack delay"});
                check_value(h_dat_o, expected, what);
            end
            h_cyc = 1'b0;
            h_stb = 1'b0;
            @(posedge aclk);  // Port is back in idle after this edge
            #2;
        end
    endtask

    // Words 4 and 5 hold the applied values, not the ones read back
    task automatic check_host_view(input int r);
        int base;
        base = r * STIM_COLS;
        for (int k = 0; k < 4; k++) begin
            host_read(wb_adr_t'(k * 4), stim_mem[base+k], "host statistics word");
        end
        host_read(8'h10, stim_mem[base+7], "host applied scale");
        host_read(8'h14, stim_mem[base+8] & 32'h0000ffff, "host applied offset");
        host_read(8'h40, wb_dat_t'(SCALE_DELTA), "host scale step");
        host_read(8'h44, 32'd25, "host offset step");
    endtask

    task automatic run_round(input int r);
        int base;
        int polls;
        base  = r * STIM_COLS;
        polls = int'(stim_mem[base+6]);
        for (int i = 1; i <= polls; i++) begin
            expect_read(ADR_CTRL, "status poll");
            if (i == 1 && r > 0) check_host_view(r - 1);  // Loop stalls on this poll
            send_ack((i == polls) ? 32'h2 : 32'h5);       // Done is bit 1 only
        end
        for (int k = 0; k < INFO_WORDS; k++) begin
            expect_read(wb_adr_t'(k * 4), "statistics read");
            send_ack(stim_mem[base+k]);
        end
        expect_write(ADR_SCALE, stim_mem[base+7], "next scale");
        expect_write(ADR_OFFSET, stim_mem[base+8], "next offset");
        expect_commands();
    endtask

    initial begin
        seed        = 32'hd788;
        errors      = 0;
        timeouts    = 0;
        wb_rst_i    = 1'b1;
        agc_reset_i = 1'b0;
        m_ack       = 1'b0;
        m_dat_i     = '0;
        h_cyc       = 1'b0;
        h_stb       = 1'b0;
        h_we        = 1'b0;
        h_adr       = '0;
        h_dat_i     = '0;
        h_sel       = 4'hf;
        $readmemh("agc_stimulus.txt", stim_mem);

        repeat (16) @(posedge aclk);
        #2;
        wb_rst_i = 1'b0;

        expect_startup();
        for (int r = 0; r < ROUNDS; r++) begin
            run_round(r);
        end

        // Hold the next poll, look from the host side, then restart mid-loop
        expect_read(ADR_CTRL, "status poll");
        check_host_view(ROUNDS - 1);
        agc_reset_i = 1'b1;
        @(posedge aclk);
        #2;
        agc_reset_i = 1'b0;
        check_value(wb_dat_t'(m_cyc), 32'd0, "bus cycle after loop restart");
        check_value(wb_dat_t'(m_sel), 32'd0, "byte select after loop restart");
        expect_startup();
        finish_run();
    end

endmodule

// File: agc_stimulus.txt
// w0 w1(rms sq) w2(above) w3(below) w4(scale) w5(offset) polls exp_scale exp_offset
// One round per line, hex, offsets as written on the bus
aaaa0000 00028000 00000064 0000000a 00000708 00000000 00000001 000006ea ffffffe7
11111111 00020000 0000000a 0000000f 00000500 0000ffe7 00000003 000006ea ffffffe7
22222222 0200a123 00000003 00000028 0001fbd0 0000ff9c 00000002 0001fbd0 ffffffb5
33333333 00190000 00000032 0000002d 0000012c 00001234 00000001 0000012c ffffffb5
44444444 00001fff 00000000 00000006 00001000 00000010 00000004 0000101e 00000029
55555555 00022000 ffffffff 00000010 0000012d 0000ff38 00000002 0000010f ffffff1f

// File: flist.f
agc_pkg.sv
agc_seq_counter.sv
agc_info_regs.sv
agc_step_calc.sv
agc_status_port.sv
agc_loop_fsm.sv
agc_control_loop.sv
agc_control_loop_checker.sv
agc_control_loop_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module agc_control_loop_tb -f flist.f -o agc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/agc_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
